// ==== design/tap_consts.svh ====
// TAP constants
// IR width, device identity, IR capture pattern and the TMS reset count
// Shared by the package and the RTL blocks of the debug TAP

`ifndef TAP_CONSTS_SVH
`define TAP_CONSTS_SVH

// Instruction register width
`define TAP_IR_LEN 4

// Device identity shifted out after reset
// Version in [31:28], part number in [27:12]
// Manufacturer code in [11:1]
// Bit 0 is always set, as the standard requires
`define TAP_IDCODE_VALUE 32'h10102001

// Fixed IR capture value
// Low bits 01 as required, upper bits chosen to catch stuck-at faults
`define TAP_IR_CAPTURE 4'b0101

// TMS-high clocks that reach Test-Logic-Reset from any state
`define TAP_TMS_RESET_CNT 5

`endif

// ==== design/tap_pkg.sv ====
// TAP types
// Controller states, instruction opcodes and the strobe and select structs

package tap_pkg;

  `include "tap_consts.svh"

  // 16 controller states, codes follow the 1149.1 state diagram
  typedef enum logic [3:0] {
    TEST_LOGIC_RESET = 4'hF,
    RUN_TEST_IDLE    = 4'hC,
    SELECT_DR_SCAN   = 4'h7,
    CAPTURE_DR       = 4'h6,
    SHIFT_DR         = 4'h2,
    EXIT1_DR         = 4'h1,
    PAUSE_DR         = 4'h3,
    EXIT2_DR         = 4'h0,
    UPDATE_DR        = 4'h5,
    SELECT_IR_SCAN   = 4'h4,
    CAPTURE_IR       = 4'hE,
    SHIFT_IR         = 4'hA,
    EXIT1_IR         = 4'h9,
    PAUSE_IR         = 4'hB,
    EXIT2_IR         = 4'h8,
    UPDATE_IR        = 4'hD
  } tap_state_e;

  // Opcodes, anything not listed behaves as bypass
  typedef enum logic [`TAP_IR_LEN-1:0] {
    INSTR_IDCODE  = 4'b0010,
    INSTR_MEMORY  = 4'b0100,
    INSTR_FIFO    = 4'b0101,
    INSTR_CONFREG = 4'b0110,
    INSTR_BYPASS  = 4'b1111
  } tap_instr_e;

  // DR path strobes, high while in the matching state
  typedef struct packed {
    logic capture;
    logic shift;
    logic exit1;
    logic update;
  } tap_dr_ctrl_t;

  // IR path strobes, reset marks Test-Logic-Reset
  typedef struct packed {
    logic capture;
    logic shift;
    logic update;
    logic reset;
  } tap_ir_ctrl_t;

  // One-hot register selects
  typedef struct packed {
    logic idcode;
    logic memory;
    logic fifo;
    logic confreg;
    logic bypass;
  } tap_sel_t;

endpackage

// ==== design/tap_fsm.sv ====
// TAP controller
// Encoded 16-state JTAG state machine stepped by TMS on rising TCK
// Decodes the current state into level strobes for the DR and IR paths

`timescale 1ns/1ns

`include "tap_consts.svh"

module tap_fsm (
  input  logic                  tck_i,
  input  logic                  rst_ni,
  input  logic                  tms_i,
  output tap_pkg::tap_dr_ctrl_t dr_ctrl_o,
  output tap_pkg::tap_ir_ctrl_t ir_ctrl_o
);

  tap_pkg::tap_state_e state_q, state_d;

  // Standard TMS transitions
  always_comb
  begin
    case (state_q)
      tap_pkg::TEST_LOGIC_RESET:
        state_d = tms_i ? tap_pkg::TEST_LOGIC_RESET : tap_pkg::RUN_TEST_IDLE;
      tap_pkg::RUN_TEST_IDLE:
        state_d = tms_i ? tap_pkg::SELECT_DR_SCAN : tap_pkg::RUN_TEST_IDLE;
      // DR column
      tap_pkg::SELECT_DR_SCAN:
        state_d = tms_i ? tap_pkg::SELECT_IR_SCAN : tap_pkg::CAPTURE_DR;
      tap_pkg::CAPTURE_DR:
        state_d = tms_i ? tap_pkg::EXIT1_DR : tap_pkg::SHIFT_DR;
      tap_pkg::SHIFT_DR:
        state_d = tms_i ? tap_pkg::EXIT1_DR : tap_pkg::SHIFT_DR;
      tap_pkg::EXIT1_DR:
        state_d = tms_i ? tap_pkg::UPDATE_DR : tap_pkg::PAUSE_DR;
      tap_pkg::PAUSE_DR:
        state_d = tms_i ? tap_pkg::EXIT2_DR : tap_pkg::PAUSE_DR;
      tap_pkg::EXIT2_DR:
        state_d = tms_i ? tap_pkg::UPDATE_DR : tap_pkg::SHIFT_DR; // Resume shifting
      tap_pkg::UPDATE_DR:
        state_d = tms_i ? tap_pkg::SELECT_DR_SCAN : tap_pkg::RUN_TEST_IDLE;
      // IR column
      tap_pkg::SELECT_IR_SCAN:
        state_d = tms_i ? tap_pkg::TEST_LOGIC_RESET : tap_pkg::CAPTURE_IR;
      tap_pkg::CAPTURE_IR:
        state_d = tms_i ? tap_pkg::EXIT1_IR : tap_pkg::SHIFT_IR;
      tap_pkg::SHIFT_IR:
        state_d = tms_i ? tap_pkg::EXIT1_IR : tap_pkg::SHIFT_IR;
      tap_pkg::EXIT1_IR:
        state_d = tms_i ? tap_pkg::UPDATE_IR : tap_pkg::PAUSE_IR;
      tap_pkg::PAUSE_IR:
        state_d = tms_i ? tap_pkg::EXIT2_IR : tap_pkg::PAUSE_IR;
      tap_pkg::EXIT2_IR:
        state_d = tms_i ? tap_pkg::UPDATE_IR : tap_pkg::SHIFT_IR;
      tap_pkg::UPDATE_IR:
        state_d = tms_i ? tap_pkg::SELECT_DR_SCAN : tap_pkg::RUN_TEST_IDLE;
      default:
        state_d = tap_pkg::TEST_LOGIC_RESET;                    // All codes used, safety only
    endcase
  end

  always_ff @(posedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
      state_q <= tap_pkg::TEST_LOGIC_RESET;
    else
      state_q <= state_d;
  end

  // State decode into strobes
  always_comb
  begin
    dr_ctrl_o.capture = (state_q == tap_pkg::CAPTURE_DR);
    dr_ctrl_o.shift   = (state_q == tap_pkg::SHIFT_DR);
    dr_ctrl_o.exit1   = (state_q == tap_pkg::EXIT1_DR);     // IDCODE reload
    dr_ctrl_o.update  = (state_q == tap_pkg::UPDATE_DR);

    ir_ctrl_o.capture = (state_q == tap_pkg::CAPTURE_IR);
    ir_ctrl_o.shift   = (state_q == tap_pkg::SHIFT_IR);
    ir_ctrl_o.update  = (state_q == tap_pkg::UPDATE_IR);
    ir_ctrl_o.reset   = (state_q == tap_pkg::TEST_LOGIC_RESET);
  end

  // Five TMS-high clocks reach reset from anywhere, no history register needed
  assert property (@(posedge tck_i) disable iff (!rst_ni)
    tms_i [* `TAP_TMS_RESET_CNT] |=> state_q == tap_pkg::TEST_LOGIC_RESET)
  else $error("TAP not in Test-Logic-Reset after %0d TMS-high clocks",
              `TAP_TMS_RESET_CNT);

  // No X or Z in the state register
  assert property (@(posedge tck_i) disable iff (!rst_ni) !$isunknown(state_q))
  else $error("TAP state unknown");

endmodule

// ==== design/tap_ir.sv ====
// TAP instruction register
// Capture and shift stage, latched instruction and the one-hot decode
// Latched value falls back to IDCODE in Test-Logic-Reset

`timescale 1ns/1ns

`include "tap_consts.svh"

module tap_ir (
  input  logic                  tck_i,
  input  logic                  rst_ni,
  input  logic                  td_i,
  input  tap_pkg::tap_ir_ctrl_t ir_ctrl_i,
  output logic                  ir_tdo_o,
  output tap_pkg::tap_sel_t     sel_o
);

  logic [`TAP_IR_LEN-1:0] shift_q;   // Shift stage
  logic [`TAP_IR_LEN-1:0] instr_q;   // Active instruction

  // Shift stage with TDI in at the MSB and the LSB out first
  always_ff @(posedge tck_i)
  begin
    if (ir_ctrl_i.capture)
      shift_q <= `TAP_IR_CAPTURE;                       // Fixed pattern for fault detection
    else if (ir_ctrl_i.shift)
      shift_q <= {td_i, shift_q[`TAP_IR_LEN-1:1]};
  end

  assign ir_tdo_o = shift_q[0];

  // Latched instruction loads on the edge leaving Update-IR
  always_ff @(posedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
      instr_q <= tap_pkg::INSTR_IDCODE;
    else if (ir_ctrl_i.reset)
      instr_q <= tap_pkg::INSTR_IDCODE;                  // IDCODE again in Test-Logic-Reset
    else if (ir_ctrl_i.update)
      instr_q <= shift_q;
  end

  // Decode to one-hot selects
  always_comb
  begin
    sel_o = '0;
    case (instr_q)
      tap_pkg::INSTR_IDCODE:
        sel_o.idcode = 1'b1;
      tap_pkg::INSTR_MEMORY:
        sel_o.memory = 1'b1;   // Memory chain
      tap_pkg::INSTR_FIFO:
        sel_o.fifo = 1'b1;     // FIFO chain
      tap_pkg::INSTR_CONFREG:
        sel_o.confreg = 1'b1;  // Config register chain
      tap_pkg::INSTR_BYPASS:
        sel_o.bypass = 1'b1;
      default:
        sel_o.bypass = 1'b1;   // Undefined codes bypass
    endcase
  end

  // Capture, shift, update and reset never overlap
  // Shift stage and latch priorities rely on it
  assert property (@(posedge tck_i) disable iff (!rst_ni) $onehot0(ir_ctrl_i))
  else $error("TAP IR strobes overlap: %b", ir_ctrl_i);

endmodule

// ==== design/tap_data_regs.sv ====
// TAP data registers
// 32-bit IDCODE shift register and the one-bit bypass register

`timescale 1ns/1ns

`include "tap_consts.svh"

module tap_data_regs (
  input  logic                  tck_i,
  input  logic                  rst_ni,
  input  logic                  td_i,
  input  tap_pkg::tap_dr_ctrl_t dr_ctrl_i,
  input  tap_pkg::tap_sel_t     sel_i,
  output logic                  idcode_tdo_o,
  output logic                  bypass_tdo_o
);

  logic [31:0] idcode_q;
  logic        bypass_q;

  // IDCODE register
  // Holds the identity out of reset so a first Shift-DR reads it
  always_ff @(posedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
      idcode_q <= `TAP_IDCODE_VALUE;
    else if (sel_i.idcode && dr_ctrl_i.shift)
      idcode_q <= {td_i, idcode_q[31:1]};               // LSB first
    else if (sel_i.idcode && (dr_ctrl_i.capture || dr_ctrl_i.exit1))
      idcode_q <= `TAP_IDCODE_VALUE;                    // Reload for the next read
  end

  // Bypass flop, one cycle of delay through any DR shift
  always_ff @(posedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
      bypass_q <= 1'b0;
    else if (dr_ctrl_i.shift)
      bypass_q <= td_i;
  end

  assign idcode_tdo_o = idcode_q[0];
  assign bypass_tdo_o = bypass_q;

endmodule

// ==== design/tap_tdo_mux.sv ====
// TAP output path
// Retimes shift-IR and the selects on falling TCK, picks the scan source
// and registers TDO on the falling edge

`timescale 1ns/1ns

module tap_tdo_mux (
  input  logic                  tck_i,
  input  logic                  rst_ni,
  input  tap_pkg::tap_ir_ctrl_t ir_ctrl_i,
  input  tap_pkg::tap_sel_t     sel_i,
  input  logic                  ir_tdo_i,
  input  logic                  idcode_tdo_i,
  input  logic                  bypass_tdo_i,
  input  logic                  memory_out_i,
  input  logic                  fifo_out_i,
  input  logic                  confreg_out_i,
  output logic                  td_o
);

  logic              shift_ir_q;   // Falling-edge copy
  tap_pkg::tap_sel_t sel_q;        // Falling-edge copy
  logic              tdo_d;

  // Half-cycle retiming of the controls
  always_ff @(negedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      shift_ir_q <= 1'b0;
      sel_q      <= '{idcode: 1'b1, default: 1'b0};   // Matches instruction after reset
    end
    else
    begin
      shift_ir_q <= ir_ctrl_i.shift;
      sel_q      <= sel_i;
    end
  end

  // Source select, IR wins during Shift-IR
  always_comb
  begin
    if (shift_ir_q)
      tdo_d = ir_tdo_i;
    else if (sel_q.idcode)
      tdo_d = idcode_tdo_i;
    else if (sel_q.memory)
      tdo_d = memory_out_i;
    else if (sel_q.fifo)
      tdo_d = fifo_out_i;
    else if (sel_q.confreg)
      tdo_d = confreg_out_i;
    else
      tdo_d = bypass_tdo_i;   // Bypass and undefined opcodes
  end

  // TDO changes on falling TCK, stable for the next rising edge
  always_ff @(negedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
      td_o <= 1'b0;
    else
      td_o <= tdo_d;
  end

endmodule

// ==== design/tap_top.sv ====
// Debug TAP top level
// Controller, instruction register, data registers and the TDO path
// Exposes the DR strobes and chain selects for memory, FIFO and confreg

`timescale 1ns/1ns

module tap_top (
  input  logic tck_i,
  input  logic rst_ni,
  input  logic tms_i,
  input  logic td_i,
  input  logic memory_out_i,    // Chain returns
  input  logic fifo_out_i,
  input  logic confreg_out_i,
  output logic td_o,
  output logic scan_in_o,       // TDI to the chains
  output logic shift_dr_o,
  output logic update_dr_o,
  output logic capture_dr_o,
  output logic memory_sel_o,
  output logic fifo_sel_o,
  output logic confreg_sel_o
);

  tap_pkg::tap_dr_ctrl_t dr_ctrl;
  tap_pkg::tap_ir_ctrl_t ir_ctrl;
  tap_pkg::tap_sel_t     sel;
  logic                  ir_tdo;
  logic                  idcode_tdo;
  logic                  bypass_tdo;

  tap_fsm tap_fsm_i (
    .tck_i     (tck_i),
    .rst_ni    (rst_ni),
    .tms_i     (tms_i),
    .dr_ctrl_o (dr_ctrl),
    .ir_ctrl_o (ir_ctrl)
  );

  tap_ir tap_ir_i (
    .tck_i     (tck_i),
    .rst_ni    (rst_ni),
    .td_i      (td_i),
    .ir_ctrl_i (ir_ctrl),
    .ir_tdo_o  (ir_tdo),
    .sel_o     (sel)
  );

  tap_data_regs tap_data_regs_i (
    .tck_i        (tck_i),
    .rst_ni       (rst_ni),
    .td_i         (td_i),
    .dr_ctrl_i    (dr_ctrl),
    .sel_i        (sel),
    .idcode_tdo_o (idcode_tdo),
    .bypass_tdo_o (bypass_tdo)
  );

  tap_tdo_mux tap_tdo_mux_i (
    .tck_i         (tck_i),
    .rst_ni        (rst_ni),
    .ir_ctrl_i     (ir_ctrl),
    .sel_i         (sel),
    .ir_tdo_i      (ir_tdo),
    .idcode_tdo_i  (idcode_tdo),
    .bypass_tdo_i  (bypass_tdo),
    .memory_out_i  (memory_out_i),
    .fifo_out_i    (fifo_out_i),
    .confreg_out_i (confreg_out_i),
    .td_o          (td_o)
  );

  assign scan_in_o     = td_i;
  assign capture_dr_o  = dr_ctrl.capture;
  assign shift_dr_o    = dr_ctrl.shift;
  assign update_dr_o   = dr_ctrl.update;
  assign memory_sel_o  = sel.memory;
  assign fifo_sel_o    = sel.fifo;
  assign confreg_sel_o = sel.confreg;

endmodule

// ==== verif/tap_tb_tasks.svh ====
// TAP drive helpers and directed tests for the debug TAP testbench
// Tasks start and end on the falling TCK edge where the inputs change

localparam int WAIT_LIMIT = 8;   // Cycles before a wait gives up

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
  assert (got === exp)
  else
  begin
    mismatches++;
    $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
  end
endtask

task automatic check_selects(input logic mem, input logic fifo, input logic conf);
  check_value("memory_sel_o", memory_sel_o, mem);
  check_value("fifo_sel_o", fifo_sel_o, fifo);
  check_value("confreg_sel_o", confreg_sel_o, conf);
endtask

// One TCK with the given TMS
task automatic tms_clock(input logic tms);
  tms_i <= tms;
  @(posedge tck_i);
  @(negedge tck_i);
endtask

// Five TMS-high clocks reach Test-Logic-Reset from any state
task automatic tms_reset();
  repeat (`TAP_TMS_RESET_CNT)
    tms_clock(1'b1);
endtask

// n bits LSB first from Shift-xR into Exit1 while the chain inputs stream
task automatic shift_bits(input logic [31:0] din, input logic [31:0] pat, input int n,
                          output logic [31:0] dout);
  int i;
  dout = '0;
  for (i = 0; i < n; i++)
  begin
    tms_i         <= (i == n - 1);   // Last bit leaves Shift
    td_i          <= din[i];
    memory_out_i  <= pat[i];         // Three distinct chain streams
    fifo_out_i    <= ~pat[i];
    confreg_out_i <= din[i] ^ pat[i];
    @(posedge tck_i);
    dout[i] = td_o;                  // Set on the falling edge before
    check_value("scan_in_o", scan_in_o, din[i]);
    @(negedge tck_i);
  end
endtask

// Idle through Shift-IR and Update-IR back to idle
task automatic load_instr(input logic [3:0] op, output logic [31:0] captured);
  tms_clock(1'b1);
  tms_clock(1'b1);   // Select-IR-Scan
  tms_clock(1'b0);   // Capture-IR
  tms_clock(1'b0);
  shift_bits(op, '0, `TAP_IR_LEN, captured);
  tms_clock(1'b1);   // Update-IR
  tms_clock(1'b0);   // Instruction latched here
endtask

task automatic enter_shift_dr();
  tms_clock(1'b1);
  tms_clock(1'b0);
  check_value("capture_dr_o", capture_dr_o, 1'b1);
  tms_clock(1'b0);
  check_value("shift_dr_o", shift_dr_o, 1'b1);
endtask

// Full DR scan from idle with the strobes checked in their states
task automatic scan_dr(input logic [31:0] din, input logic [31:0] pat, input int n,
                       output logic [31:0] dout);
  enter_shift_dr();
  shift_bits(din, pat, n, dout);
  bypass_bit = din[n-1];           // Last bit in stays in the bypass flop
  tms_clock(1'b1);
  check_value("update_dr_o", update_dr_o, 1'b1);
  tms_clock(1'b0);
endtask

// Selects settle one edge after Test-Logic-Reset is reached
task automatic wait_selects_idle();
  int cycles;
  cycles = 0;
  while ({memory_sel_o, fifo_sel_o, confreg_sel_o} != 3'b000 && cycles < WAIT_LIMIT)
  begin
    tms_clock(1'b1);
    cycles++;
  end
  assert ({memory_sel_o, fifo_sel_o, confreg_sel_o} == 3'b000)
  else
  begin
    failures++;
    $display("Timeout at %0t: chain selects still high in Test-Logic-Reset", $time);
  end
endtask

task automatic test_idcode_after_reset();
  logic [31:0] dout;
  check_selects(1'b0, 1'b0, 1'b0);
  tms_clock(1'b0);   // Run-Test/Idle
  scan_dr($random(seed), '0, 32, dout);
  check_value("td_o", dout, `TAP_IDCODE_VALUE);
endtask

// Capture pattern comes out of Shift-IR while a random opcode goes in
task automatic test_ir_capture();
  logic [31:0] captured;
  logic [31:0] op;
  repeat (2)
  begin
    tms_reset();
    tms_clock(1'b0);
    op = $random(seed);
    load_instr(op[`TAP_IR_LEN-1:0], captured);
    check_value("td_o", captured, `TAP_IR_CAPTURE);
  end
endtask

// Bypass, undefined and chain opcodes with td_o one bit behind its source
task automatic test_scan_path(input logic [3:0] op);
  logic [31:0] din, pat, dout, captured, exp;
  logic        is_mem, is_fifo, is_conf;
  is_mem  = (op == tap_pkg::INSTR_MEMORY);
  is_fifo = (op == tap_pkg::INSTR_FIFO);
  is_conf = (op == tap_pkg::INSTR_CONFREG);
  load_instr(op, captured);
  check_selects(is_mem, is_fifo, is_conf);
  din = $random(seed);
  pat = $random(seed);
  // First bit out is the value held before the scan
  if (is_mem)
    exp = {pat[30:0], memory_out_i};
  else if (is_fifo)
    exp = {~pat[30:0], fifo_out_i};
  else if (is_conf)
    exp = {din[30:0] ^ pat[30:0], confreg_out_i};
  else
    exp = {din[30:0], bypass_bit};
  scan_dr(din, pat, 32, dout);
  check_value("td_o", dout, exp);
endtask

task automatic test_reset_from_shift();
  logic [31:0] dout, captured;
  load_instr(tap_pkg::INSTR_FIFO, captured);
  enter_shift_dr();
  tms_reset();
  check_value("capture_dr_o", capture_dr_o, 1'b0);
  check_value("shift_dr_o", shift_dr_o, 1'b0);
  check_value("update_dr_o", update_dr_o, 1'b0);
  wait_selects_idle();
  tms_clock(1'b0);
  scan_dr($random(seed), '0, 32, dout);   // IDCODE selected again
  check_value("td_o", dout, `TAP_IDCODE_VALUE);
endtask

// ==== verif/tap_tb.sv ====
// Debug TAP testbench
// Clock, reset, DUT and the directed test sequence with a closing report

`timescale 1ns/1ns

`include "tap_consts.svh"

module tap_tb;

  logic tck_i, rst_ni, tms_i, td_i;
  logic memory_out_i, fifo_out_i, confreg_out_i;            // Chain returns
  logic td_o, scan_in_o, shift_dr_o, update_dr_o, capture_dr_o;
  logic memory_sel_o, fifo_sel_o, confreg_sel_o;

  integer seed;         // $random state
  int     mismatches;
  int     failures;     // Timeouts
  logic   bypass_bit;   // Expected bypass flop content

  tap_top tap_top_i (.*);

  `include "tap_tb_tasks.svh"

  // 20 ns TCK
  initial
  begin
    tck_i = 1'b0;
    forever
      #10 tck_i = ~tck_i;
  end

  initial
  begin
    seed          = 32'hbe29048a;
    mismatches    = 0;
    failures      = 0;
    bypass_bit    = 1'b0;    // Bypass flop resets low
    rst_ni        = 1'b0;
    tms_i         = 1'b1;
    td_i          = 1'b0;
    memory_out_i  = 1'b0;
    fifo_out_i    = 1'b0;
    confreg_out_i = 1'b0;
    repeat (4)
      @(posedge tck_i);
    @(negedge tck_i);
    rst_ni <= 1'b1;          // Released on a falling edge

    test_idcode_after_reset();
    test_ir_capture();
    test_scan_path(tap_pkg::INSTR_BYPASS);
    test_scan_path(4'b0000);   // Undefined opcode
    test_scan_path(tap_pkg::INSTR_MEMORY);
    test_scan_path(tap_pkg::INSTR_FIFO);
    test_scan_path(tap_pkg::INSTR_CONFREG);
    test_reset_from_shift();

    $display("Errors: %0d mismatches, %0d timeouts", mismatches, failures);
    if (mismatches + failures == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+design
+incdir+verif
design/tap_pkg.sv
design/tap_fsm.sv
design/tap_ir.sv
design/tap_data_regs.sv
design/tap_tdo_mux.sv
design/tap_top.sv
verif/tap_tb.sv

// ==== Bender.yml ====
package:
  name: jtag_tap

sources:
  - include_dirs:
      - design
    files:
      - design/tap_pkg.sv
      - design/tap_fsm.sv
      - design/tap_ir.sv
      - design/tap_data_regs.sv
      - design/tap_tdo_mux.sv
      - design/tap_top.sv
  - target: test
    include_dirs:
      - design
      - verif
    files:
      - verif/tap_tb.sv
